//--- verilog/tdc_pkg.sv
// tdc measurement engine shared constants and types

package tdc_pkg;

    // sample rate over DV_CLK, in groups of four samples
    localparam int CLKDV   = 4;
    localparam int SAMPLES = 4 * CLKDV;    // samples per DV_CLK word

    // MSB is the earliest sample, bit 0 the latest
    typedef logic [SAMPLES-1:0] sample_word_t;

    typedef logic [4:0] edge_pos_t;        // sample count or edge position

    localparam logic [3:0] DATA_IDENTIFIER = 4'b0100;

    localparam logic [11:0] TDC_MAX = 12'd4095;   // saturated pulse length

    // trigger distance codes
    localparam logic [8:0] TRIG_NONE = 9'd255;    // no trigger or error
    localparam logic [8:0] TRIG_OVF  = 9'd254;    // distance overflow

    localparam int FIFO_DEPTH = 16;               // event words buffered
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_ARMED = 2'b01,
        ST_COUNT = 2'b10
    } tdc_state_t;

endpackage

//--- verilog/sample_edge_scan.sv
// rising edge finder and ones counter for one deserialized sample word
`timescale 1ns/1ps

module sample_edge_scan import tdc_pkg::*; (
    input  logic         DV_CLK,
    input  logic         RST_DV_CLK,
    input  sample_word_t word,
    output logic         found,
    output edge_pos_t    ones,
    output edge_pos_t    length,
    output logic         ambig,
    output logic         any_zero
);

    logic             prev_lsb;    // latest sample of the previous word
    logic [SAMPLES:0] ext_word;    // word with one earlier sample on top
    edge_pos_t        all_ones;

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK) begin
            prev_lsb <= 1'b0;
        end else begin
            prev_lsb <= word[0];
        end
    end

    assign ext_word = {prev_lsb, word};

    // walk from the latest sample towards the earliest one
    always_comb begin
        all_ones = '0;
        ones     = '0;
        length   = '0;
        found    = 1'b0;
        for (int i = 0; i < SAMPLES; i++) begin
            all_ones = all_ones + edge_pos_t'(ext_word[i]);
            if (!found) begin
                ones = ones + edge_pos_t'(ext_word[i]);    // stops counting at the edge
            end
            if (ext_word[i] && !ext_word[i+1] && !found) begin
                length = edge_pos_t'(i + 1);
                found  = 1'b1;
            end
        end
    end

    // ones above the edge mean a second pulse in the word
    assign ambig    = (all_ones != ones);
    assign any_zero = ~&word;

endmodule

//--- verilog/tdc_measure_fsm.sv
// tdc state machine with pulse length accumulation, timestamp and event counting
`timescale 1ns/1ps

module tdc_measure_fsm import tdc_pkg::*; (
    input  logic        DV_CLK,
    input  logic        RST_DV_CLK,
    input  logic        found,
    input  edge_pos_t   ones,
    input  logic        ambig,
    input  logic        any_zero,
    input  logic        en,
    input  logic        en_ext,
    input  logic        ext_en,
    input  logic        en_arm,
    input  logic        arm,
    input  logic [15:0] timestamp,
    output logic        in_count,
    output logic        start,
    output logic        finish,
    output logic [11:0] tdc_val,
    output logic        tdc_err,
    output logic [15:0] tdc_ts,
    output logic [31:0] event_count
);

    tdc_state_t  state;
    tdc_state_t  next_state;
    logic        enable;
    logic [12:0] tdc_pre;    // running length, bit 12 catches overflow
    logic [12:0] tdc_sum;

    assign enable = en | (en_ext & ext_en);

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (found && enable && !en_arm) begin
                    next_state = ST_COUNT;
                end else if (arm && enable && en_arm) begin
                    next_state = ST_ARMED;    // wait for the next edge
                end
            end
            ST_ARMED: begin
                if (!enable) begin
                    next_state = ST_IDLE;
                end else if (found) begin
                    next_state = ST_COUNT;
                end
            end
            ST_COUNT: begin
                if (any_zero || !enable) begin
                    next_state = ST_IDLE;    // pulse has ended
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    assign in_count = (state == ST_COUNT);
    assign start    = (state != ST_COUNT) && (next_state == ST_COUNT);
    assign finish   = in_count && (next_state == ST_IDLE);
    assign tdc_err  = ambig;
    assign tdc_sum  = tdc_pre + 13'(ones);

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK || finish) begin
            tdc_pre <= '0;
        end else if (start) begin
            tdc_pre <= ambig ? 13'd0 : 13'(ones);
        end else if (in_count) begin
            if (tdc_sum > 13'(TDC_MAX)) begin
                tdc_pre <= 13'(TDC_MAX);    // saturate
            end else begin
                tdc_pre <= tdc_sum;
            end
        end
    end

    // final value includes the ones of the closing word
    assign tdc_val = (ambig || tdc_pre == '0)  ? 12'd0 :
                     (tdc_sum > 13'(TDC_MAX))  ? TDC_MAX :
                     found                     ? tdc_pre[11:0] :
                                                 tdc_sum[11:0];

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK) begin
            tdc_ts      <= '0;
            event_count <= '0;
        end else begin
            if (start) begin
                tdc_ts <= timestamp;
            end
            if (finish) begin
                event_count <= event_count + 32'd1;
            end
        end
    end

endmodule

//--- verilog/trig_distance.sv
// trigger to tdc edge distance in samples, with error and overflow codes
`timescale 1ns/1ps

module trig_distance import tdc_pkg::*; (
    input  logic       DV_CLK,
    input  logic       RST_DV_CLK,
    input  logic       trig_found,
    input  edge_pos_t  trig_ones,
    input  edge_pos_t  trig_length,
    input  logic       trig_ambig,
    input  logic       tdc_found,
    input  edge_pos_t  tdc_length,
    input  logic       tdc_err,
    input  logic       in_count,
    input  logic       finish,
    output logic [8:0] trig_dist
);

    logic      trig_hit;
    logic      trig_err;
    logic      cnt_trig;    // trigger seen, tdc edge still pending
    edge_pos_t trig_cnt;
    logic [8:0] dist_sum;

    // an edge needs at least one high sample behind it
    assign trig_hit = trig_found && (trig_ones != '0);

    assign trig_err = trig_ambig
                   || (trig_hit && tdc_found && (tdc_length > trig_length))    // trigger after tdc
                   || (trig_hit && in_count);

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK) begin
            cnt_trig <= 1'b0;
        end else if (tdc_found) begin
            cnt_trig <= 1'b0;
        end else if (trig_hit && !tdc_err && !trig_err) begin
            cnt_trig <= 1'b1;
        end
    end

    // samples to add for the current word
    always_comb begin
        if (!cnt_trig && trig_hit && tdc_found) begin
            trig_cnt = trig_length - tdc_length;    // both edges in one word
        end else if (!cnt_trig && trig_hit) begin
            trig_cnt = trig_length;
        end else if (cnt_trig && tdc_found) begin
            trig_cnt = edge_pos_t'(SAMPLES) - tdc_length;
        end else if (cnt_trig) begin
            trig_cnt = edge_pos_t'(SAMPLES);        // whole word in between
        end else begin
            trig_cnt = '0;
        end
    end

    assign dist_sum = trig_dist + 9'(trig_cnt);

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK || finish) begin
            trig_dist <= TRIG_NONE;
        end else if (trig_hit) begin
            if (trig_err || cnt_trig || tdc_err) begin
                trig_dist <= TRIG_NONE;
            end else begin
                trig_dist <= 9'(trig_cnt);
            end
        end else if (cnt_trig && trig_dist != TRIG_NONE) begin
            if (tdc_err) begin
                trig_dist <= TRIG_NONE;
            end else if (dist_sum > TRIG_OVF) begin
                trig_dist <= TRIG_OVF;    // too far apart
            end else begin
                trig_dist <= dist_sum;
            end
        end
    end

endmodule

//--- verilog/event_word_fifo.sv
// event word formatting, write filter, synchronous FIFO and lost event counter
`timescale 1ns/1ps

module event_word_fifo import tdc_pkg::*; (
    input  logic        DV_CLK,
    input  logic        RST_DV_CLK,
    input  logic        finish,
    input  logic [11:0] tdc_val,
    input  logic [15:0] tdc_ts,
    input  logic [31:0] event_count,
    input  logic [8:0]  trig_dist,
    input  logic        en_write_ts,
    input  logic        en_trig_dist,
    input  logic        no_write_trig_err,
    input  logic        fifo_read,
    output logic [31:0] fifo_data,
    output logic        fifo_empty,
    output logic [7:0]  lost_count
);

    logic [31:0]      mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;    // top bit marks the wrap
    logic [FIFO_AW:0] rd_ptr;
    logic             full;
    logic             trig_drop;
    logic             wr_en;
    logic             rd_en;
    logic [31:0]      event_word;

    always_comb begin
        event_word = {DATA_IDENTIFIER, (en_write_ts ? tdc_ts : event_count[15:0]), tdc_val};
        if (en_trig_dist) begin
            event_word[27:20] = trig_dist[7:0];    // distance replaces upper bits
        end
    end

    assign trig_drop = en_trig_dist && no_write_trig_err && (trig_dist == TRIG_NONE);

    assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW])
               && (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign fifo_empty = (wr_ptr == rd_ptr);

    assign wr_en = finish && !full && !trig_drop;
    assign rd_en = fifo_read && !fifo_empty;    // reads on empty are ignored

    always_ff @(posedge DV_CLK) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= event_word;
        end
    end

    assign fifo_data = mem[rd_ptr[FIFO_AW-1:0]];    // oldest word

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_DV_CLK) begin
            lost_count <= '0;
        end else if (finish && full && lost_count != 8'hFF) begin
            lost_count <= lost_count + 8'd1;    // saturates at 255
        end
    end

endmodule

//--- verilog/tdc_core_top.sv
// DV_CLK domain tdc core with edge scanners, measurement FSM, trigger distance and FIFO
`timescale 1ns/1ps

module tdc_core_top import tdc_pkg::*; (
    input  logic         DV_CLK,
    input  logic         RST_DV_CLK,
    input  sample_word_t tdc_word,
    input  sample_word_t trig_word,
    input  logic [15:0]  timestamp,
    input  logic         en,
    input  logic         en_ext,
    input  logic         ext_en,
    input  logic         en_arm,
    input  logic         arm,
    input  logic         en_write_ts,
    input  logic         en_trig_dist,
    input  logic         no_write_trig_err,
    input  logic         fifo_read,
    output logic [31:0]  fifo_data,
    output logic         fifo_empty,
    output logic [31:0]  event_count,
    output logic [7:0]   lost_count
);

    logic        tdc_found;
    edge_pos_t   tdc_ones;
    edge_pos_t   tdc_length;
    logic        tdc_ambig;
    logic        tdc_any_zero;
    logic        trig_found;
    edge_pos_t   trig_ones;
    edge_pos_t   trig_length;
    logic        trig_ambig;
    logic        in_count;
    logic        finish;
    logic [11:0] tdc_val;
    logic        tdc_err;
    logic [15:0] tdc_ts;
    logic [8:0]  trig_dist;

    sample_edge_scan tdc_scan (
        .DV_CLK     (DV_CLK),
        .RST_DV_CLK (RST_DV_CLK),
        .word       (tdc_word),
        .found      (tdc_found),
        .ones       (tdc_ones),
        .length     (tdc_length),
        .ambig      (tdc_ambig),
        .any_zero   (tdc_any_zero)
    );

    sample_edge_scan trig_scan (
        .DV_CLK     (DV_CLK),
        .RST_DV_CLK (RST_DV_CLK),
        .word       (trig_word),
        .found      (trig_found),
        .ones       (trig_ones),
        .length     (trig_length),
        .ambig      (trig_ambig),
        .any_zero   ()    // pulse end only matters on the tdc side
    );

    tdc_measure_fsm measure (
        .DV_CLK      (DV_CLK),
        .RST_DV_CLK  (RST_DV_CLK),
        .found       (tdc_found),
        .ones        (tdc_ones),
        .ambig       (tdc_ambig),
        .any_zero    (tdc_any_zero),
        .en          (en),
        .en_ext      (en_ext),
        .ext_en      (ext_en),
        .en_arm      (en_arm),
        .arm         (arm),
        .timestamp   (timestamp),
        .in_count    (in_count),
        .start       (),
        .finish      (finish),
        .tdc_val     (tdc_val),
        .tdc_err     (tdc_err),
        .tdc_ts      (tdc_ts),
        .event_count (event_count)
    );

    trig_distance distance (
        .DV_CLK      (DV_CLK),
        .RST_DV_CLK  (RST_DV_CLK),
        .trig_found  (trig_found),
        .trig_ones   (trig_ones),
        .trig_length (trig_length),
        .trig_ambig  (trig_ambig),
        .tdc_found   (tdc_found),
        .tdc_length  (tdc_length),
        .tdc_err     (tdc_err),
        .in_count    (in_count),
        .finish      (finish),
        .trig_dist   (trig_dist)
    );

    event_word_fifo event_fifo (
        .DV_CLK            (DV_CLK),
        .RST_DV_CLK        (RST_DV_CLK),
        .finish            (finish),
        .tdc_val           (tdc_val),
        .tdc_ts            (tdc_ts),
        .event_count       (event_count),
        .trig_dist         (trig_dist),
        .en_write_ts       (en_write_ts),
        .en_trig_dist      (en_trig_dist),
        .no_write_trig_err (no_write_trig_err),
        .fifo_read         (fifo_read),
        .fifo_data         (fifo_data),
        .fifo_empty        (fifo_empty),
        .lost_count        (lost_count)
    );

endmodule

//--- tests/tdc_vectors.svh
// test table for the tdc core testbench, one add_row call per test
`ifndef TDC_VECTORS_SVH
`define TDC_VECTORS_SVH

    // columns: name, config {en, en_ext, ext_en, en_arm, en_write_ts, en_trig_dist,
    // no_write_trig_err}, arm, timestamp, expect write, event word, tdc words, trig words
    // event word: id 31:28, count or timestamp 27:12, distance over 27:20, length 11:0
    task automatic load_rows();
        add_row("pulse_one_word", 7'b1000000, 1'b0, 16'h5A5A, 1'b1, 32'h4000_0008,
                128'h0FF0_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        // 4 + 8 samples across the word boundary
        add_row("pulse_two_words", 7'b1000000, 1'b0, 16'h0000, 1'b1, 32'h4000_100C,
                128'h000F_FF00_0000_0000_0000_0000_0000_0000, 128'h0);
        // 8 + 16 + 4 samples
        add_row("pulse_three_words", 7'b1000000, 1'b0, 16'h0000, 1'b1, 32'h4000_201C,
                128'h00FF_FFFF_F000_0000_0000_0000_0000_0000, 128'h0);
        add_row("pulse_ext_enable", 7'b0110000, 1'b0, 16'h0000, 1'b1, 32'h4000_3003,
                128'h0380_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        // two rising edges in one word
        add_row("ambiguous_word", 7'b1000000, 1'b0, 16'h0000, 1'b1, 32'h4000_4000,
                128'h0F0F_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        add_row("arm_blocked", 7'b1001000, 1'b0, 16'h0000, 1'b0, 32'h0000_0000,
                128'h0FF0_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        add_row("arm_timestamp", 7'b1001100, 1'b1, 16'hBEEF, 1'b1, 32'h4BEE_F004,
                128'h00F0_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        // trigger at sample 11, tdc at sample 7
        add_row("trig_same_word", 7'b1000010, 1'b0, 16'h0000, 1'b1, 32'h4040_6004,
                128'h00F0_0000_0000_0000_0000_0000_0000_0000,
                128'h0F00_0000_0000_0000_0000_0000_0000_0000);
        // trigger 2 samples before the boundary, tdc 2 samples after it
        add_row("trig_prev_word", 7'b1000010, 1'b0, 16'h0000, 1'b1, 32'h4040_7002,
                128'h0000_3000_0000_0000_0000_0000_0000_0000,
                128'h0003_0000_0000_0000_0000_0000_0000_0000);
        add_row("no_trigger", 7'b1000010, 1'b0, 16'h0000, 1'b1, 32'h4FF0_8008,
                128'h0FF0_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        add_row("no_trigger_dropped", 7'b1000011, 1'b0, 16'h0000, 1'b0, 32'h0000_0000,
                128'h0FF0_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        add_row("ext_not_enabled", 7'b0100000, 1'b0, 16'h0000, 1'b0, 32'h0000_0000,
                128'h0FF0_0000_0000_0000_0000_0000_0000_0000, 128'h0);
        table_events = 10;    // dropped words still count
    endtask

`endif

//--- tests/tdc_core_tb.sv
// testbench for the tdc core, table driven events with FIFO readout and a back-pressure burst
`timescale 1ns/1ps

module tdc_core_tb;

    logic         DV_CLK;
    logic         RST_DV_CLK;
    logic [15:0]  tdc_word;
    logic [15:0]  trig_word;
    logic [15:0]  timestamp;
    logic         en;
    logic         en_ext;
    logic         ext_en;
    logic         en_arm;
    logic         arm;
    logic         en_write_ts;
    logic         en_trig_dist;
    logic         no_write_trig_err;
    logic         fifo_read;
    logic [31:0]  fifo_data;
    logic         fifo_empty;
    logic [31:0]  event_count;
    logic [7:0]   lost_count;

    string        row_name[$];
    logic [6:0]   row_cfg[$];
    logic         row_arm[$];
    logic [15:0]  row_ts[$];
    logic         row_wr[$];
    logic [31:0]  row_exp[$];
    logic [127:0] row_tdc[$];    // first word in the top 16 bits
    logic [127:0] row_trig[$];
    int           table_events;
    int           errors;
    int           tests;
    int           failed_tests;
    int           cycles;
    int           cycle_limit;

    tdc_core_top uut (.*);

    initial begin
        DV_CLK = 1'b0;
        forever #50 DV_CLK = ~DV_CLK;
    end

    always @(posedge DV_CLK) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic add_row(input string name, input logic [6:0] cfg, input logic arm_en,
                           input logic [15:0] ts, input logic wr, input logic [31:0] exp,
                           input logic [127:0] tdc, input logic [127:0] trig);
        row_name.push_back(name);
        row_cfg.push_back(cfg);
        row_arm.push_back(arm_en);
        row_ts.push_back(ts);
        row_wr.push_back(wr);
        row_exp.push_back(exp);
        row_tdc.push_back(tdc);
        row_trig.push_back(trig);
    endtask

    `include "tdc_vectors.svh"

    // words up to the last non-zero one in either sequence
    function automatic int words_used(input logic [127:0] a, input logic [127:0] b);
        int n;
        n = 0;
        for (int k = 0; k < 8; k++) begin
            if ((a[127-16*k -: 16] | b[127-16*k -: 16]) != 16'h0000) begin
                n = k + 1;
            end
        end
        return n;
    endfunction

    task automatic step();
        @(posedge DV_CLK);
        #5;
    endtask

    task automatic pop_word();
        fifo_read = 1'b1;
        step();
        fifo_read = 1'b0;
    endtask

    task automatic set_config(input logic [6:0] cfg);
        {en, en_ext, ext_en, en_arm, en_write_ts, en_trig_dist, no_write_trig_err} = cfg;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d check(s) wrong", name, errors - errs_before);
        end
    endtask

    task automatic run_row(input int r);
        logic [127:0] tdc_seq;
        logic [127:0] trig_seq;
        int           n;
        int           waited;
        int           errs_before;
        errs_before = errors;
        tdc_seq     = row_tdc[r];
        trig_seq    = row_trig[r];
        n           = words_used(tdc_seq, trig_seq);
        set_config(row_cfg[r]);
        timestamp = row_ts[r];
        if (row_arm[r]) begin
            arm = 1'b1;    // arm pulse on an idle word
            step();
            arm = 1'b0;
        end
        for (int k = 0; k < n; k++) begin
            tdc_word  = tdc_seq[127-16*k -: 16];
            trig_word = trig_seq[127-16*k -: 16];
            step();
        end
        tdc_word  = '0;
        trig_word = '0;
        waited    = 0;
        while (fifo_empty && waited < 12) begin
            step();
            waited++;
        end
        if (row_wr[r]) begin
            assert (!fifo_empty) else begin
                $display("%s: no event word arrived within 12 cycles", row_name[r]);
                errors++;
            end
        end else begin
            assert (fifo_empty) else begin
                $display("%s: an event word was written where none belongs", row_name[r]);
                errors++;
            end
        end
        if (row_wr[r] && !fifo_empty) begin
            assert (fifo_data === row_exp[r]) else begin
                $display("ERR %s expected %h actual %h", row_name[r], row_exp[r], fifo_data);
                errors++;
            end
        end
        if (!fifo_empty) begin
            pop_word();    // keeps later rows aligned
        end
        report_test(row_name[r], errs_before);
    endtask

    // 20 eight-sample pulses with no reads, FIFO holds 16
    task automatic run_burst();
        logic [31:0] expected;
        int          errs_before;
        errs_before = errors;
        set_config(7'b1000000);
        repeat (20) begin
            tdc_word = 16'h0FF0;
            step();
            tdc_word = 16'h0000;
            step();
        end
        assert (lost_count == 8'd4) else begin
            $display("ERR backpressure_burst expected %0d actual %0d", 4, lost_count);
            errors++;
        end
        assert (event_count == 32'(table_events + 20)) else begin
            $display("ERR backpressure_burst expected %0d actual %0d",
                     table_events + 20, event_count);
            errors++;
        end
        for (int k = 0; k < 16; k++) begin
            expected = {4'h4, 16'(table_events + k), 12'd8};
            assert (!fifo_empty) else begin
                $display("backpressure_burst: FIFO ran empty after %0d words", k);
                errors++;
            end
            assert (fifo_data === expected) else begin
                $display("ERR backpressure_burst expected %h actual %h", expected, fifo_data);
                errors++;
            end
            pop_word();
        end
        assert (fifo_empty) else begin
            $display("backpressure_burst: FIFO still holds words after 16 reads");
            errors++;
        end
        report_test("backpressure_burst", errs_before);
    endtask

    initial begin
        RST_DV_CLK   = 1'b1;
        tdc_word     = '0;
        trig_word    = '0;
        timestamp    = '0;
        arm          = 1'b0;
        fifo_read    = 1'b0;
        set_config(7'b0);
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        cycles       = 0;
        load_rows();
        cycle_limit = row_name.size() * 20 + 50;
        repeat (2) @(posedge DV_CLK);
        #5;
        RST_DV_CLK = 1'b0;
        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end
        run_burst();
        $display("tests %0d, ok %0d, wrong %0d", tests, tests - failed_tests, failed_tests);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+tests
verilog/tdc_pkg.sv
verilog/sample_edge_scan.sv
verilog/tdc_measure_fsm.sv
verilog/trig_distance.sv
verilog/event_word_fifo.sv
verilog/tdc_core_top.sv
tests/tdc_core_tb.sv

//--- Makefile
# Verilator lint and simulation of the tdc core

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tdc_core_tb
RTL_TOP    ?= tdc_core_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qx '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
